// File: video_macros.svh
//------------------------------------------------
// Timing, FIFO and prefill values
// Defaults are tiny for simulation; counter widths
// must be raised together with 1920x1080 values
//------------------------------------------------
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// Horizontal line: active, front porch, sync, back porch
`define VID_HACT 8
`define VID_HFP 2
`define VID_HSP 2
`define VID_HBP 2

// Vertical frame in lines
`define VID_VACT 4
`define VID_VFP 1
`define VID_VSP 1
`define VID_VBP 1

// Counter widths, must hold line and frame totals
`define VID_HBITS 4
`define VID_VBITS 3

// Pixel FIFO, depth is a power of two here
`define FIFO_DEPTH 32
`define FIFO_ABITS 5
`define FIFO_MARGIN 4

// Pixels buffered before the timing starts
`define PREFILL_COUNT `VID_HACT

`endif

// File: videoPkg.sv
//------------------------------------------------
// Shared pixel, sync and state types
// Pixel layout follows YUYV on a 16-bit bus:
// chroma (U or V) in the upper byte, luma below
//------------------------------------------------
`default_nettype none

package videoPkg;

	//------------------------------------------------
	// Pixel
	//------------------------------------------------
	// One YUYV sample, chroma alternates U and V per pixel
	typedef struct packed
	{
		logic [7:0] chroma;
		logic [7:0] luma;
	} pixel_t;

	//------------------------------------------------
	// Display timing bundle
	//------------------------------------------------
	// All three active high
	typedef struct packed
	{
		logic hSync;
		logic vSync;
		logic de;
	} syncBundle_t;

	//------------------------------------------------
	// Start gate FSM
	//------------------------------------------------
	// HOLD keeps the timing generator in reset
	typedef enum logic
	{
		HOLD = 1'b0,
		RUN  = 1'b1
	} gateState_t;

endpackage

`default_nettype wire

// File: pixelFifo.sv
//------------------------------------------------
// Single-clock pixel FIFO, read data one cycle late
// o_full is an almost-full level, not a handshake
// Writes to a truly full buffer are dropped
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "video_macros.svh"

module pixelFifo
(
	input  logic              iFCLK,
	input  logic              iFRST,
	input  videoPkg::pixel_t  i_wrData,
	input  logic              i_wrEn,
	input  logic              i_rdEn,
	output videoPkg::pixel_t  o_rdData,
	output logic              o_full,
	output logic              o_empty
);

	localparam int DEPTH      = `FIFO_DEPTH;
	localparam int ABITS      = `FIFO_ABITS;
	localparam int FULL_LEVEL = `FIFO_DEPTH - `FIFO_MARGIN;
	localparam logic [ABITS-1:0] LAST_ADDR = ABITS'(DEPTH - 1);

	videoPkg::pixel_t mem [0:DEPTH-1];
	logic [ABITS-1:0] wrPtr;
	logic [ABITS-1:0] rdPtr;
	// One extra bit so a full buffer is distinct from empty
	logic [ABITS:0]   count;
	logic             wrOk;
	logic             rdOk;

	// Guard pointers against overflow and underflow
	assign wrOk = i_wrEn && (count != (ABITS+1)'(DEPTH));
	assign rdOk = i_rdEn && (count != '0);

	//------------------------------------------------
	// Pointers and occupancy
	//------------------------------------------------
	always_ff @(posedge iFCLK)
	begin
		if (iFRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (wrOk)
				wrPtr <= (wrPtr == LAST_ADDR) ? '0 : wrPtr + 1'b1;
			if (rdOk)
				rdPtr <= (rdPtr == LAST_ADDR) ? '0 : rdPtr + 1'b1;
			// Simultaneous read and write leaves count as is
			case ({wrOk, rdOk})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	//------------------------------------------------
	// Storage and registered read port
	//------------------------------------------------
	always_ff @(posedge iFCLK)
	begin
		if (wrOk)
			mem[wrPtr] <= i_wrData;
		// Holds last value when no read happens
		if (rdOk)
			o_rdData <= mem[rdPtr];
	end

	// Flags follow the registered count
	assign o_full  = (count >= (ABITS+1)'(FULL_LEVEL));
	assign o_empty = (count == '0);

endmodule

`default_nettype wire

// File: startGate.sv
//------------------------------------------------
// Holds display timing in reset until one line
// of pixels is buffered; releases once per reset
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "video_macros.svh"

module startGate
(
	input  logic iFCLK,
	input  logic iFRST,
	input  logic i_wrStrobe,
	output logic o_timingRst
);

	localparam int PREFILL = `PREFILL_COUNT;
	localparam int CBITS   = $clog2(PREFILL + 1);

	videoPkg::gateState_t state;
	logic [CBITS-1:0]     pixCnt;

	always_ff @(posedge iFCLK)
	begin
		if (iFRST)
		begin
			state  <= videoPkg::HOLD;
			pixCnt <= '0;
		end
		else
		begin
			case (state)
				videoPkg::HOLD:
				begin
					// Counter stops once the line is in
					if (pixCnt == CBITS'(PREFILL))
						state <= videoPkg::RUN;
					else if (i_wrStrobe)
						pixCnt <= pixCnt + 1'b1;
				end
				default:
				begin
					// Stays released until the next reset
					state <= videoPkg::RUN;
				end
			endcase
		end
	end

	assign o_timingRst = (state == videoPkg::HOLD);

endmodule

`default_nettype wire

// File: videoTimingGen.sv
//------------------------------------------------
// Display timing from H and V counters
// Order per line: active, front porch, sync, back
// porch; o_fetch leads o_sync.de by one cycle
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "video_macros.svh"

module videoTimingGen
(
	input  logic                  iFCLK,
	input  logic                  iFRST,
	input  logic                  i_timingRst,
	output videoPkg::syncBundle_t o_sync,
	output logic                  o_fetch
);

	localparam int HBITS = `VID_HBITS;
	localparam int VBITS = `VID_VBITS;
	localparam int HTOT  = `VID_HACT + `VID_HFP + `VID_HSP + `VID_HBP;
	localparam int VTOT  = `VID_VACT + `VID_VFP + `VID_VSP + `VID_VBP;

	// Compare points at counter width
	localparam logic [HBITS-1:0] H_LAST     = HBITS'(HTOT - 1);
	localparam logic [HBITS-1:0] H_ACT      = HBITS'(`VID_HACT);
	localparam logic [HBITS-1:0] HS_START   = HBITS'(`VID_HACT + `VID_HFP);
	localparam logic [HBITS-1:0] HS_END     = HBITS'(`VID_HACT + `VID_HFP + `VID_HSP);
	localparam logic [VBITS-1:0] V_LAST     = VBITS'(VTOT - 1);
	localparam logic [VBITS-1:0] V_ACT      = VBITS'(`VID_VACT);
	localparam logic [VBITS-1:0] VS_START   = VBITS'(`VID_VACT + `VID_VFP);
	localparam logic [VBITS-1:0] VS_END     = VBITS'(`VID_VACT + `VID_VFP + `VID_VSP);

	logic                  rst;
	logic [HBITS-1:0]      hCnt;
	logic [VBITS-1:0]      vCnt;
	logic                  lineEnd;
	// Decoded one cycle ahead of the output bundle
	videoPkg::syncBundle_t earlySync;

	// Either reset source parks the generator
	assign rst     = iFRST | i_timingRst;
	assign lineEnd = (hCnt == H_LAST);

	//------------------------------------------------
	// Position counters
	//------------------------------------------------
	always_ff @(posedge iFCLK)
	begin
		if (rst)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else
		begin
			hCnt <= lineEnd ? '0 : hCnt + 1'b1;
			// Line count steps at the end of each line
			if (lineEnd)
				vCnt <= (vCnt == V_LAST) ? '0 : vCnt + 1'b1;
		end
	end

	//------------------------------------------------
	// Decode and output registers
	//------------------------------------------------
	always_ff @(posedge iFCLK)
	begin
		if (rst)
		begin
			earlySync <= '0;
			o_sync    <= '0;
		end
		else
		begin
			earlySync.de    <= (hCnt < H_ACT) && (vCnt < V_ACT);
			earlySync.hSync <= (hCnt >= HS_START) && (hCnt < HS_END);
			earlySync.vSync <= (vCnt >= VS_START) && (vCnt < VS_END);
			// Second stage, lines up with FIFO read latency
			o_sync <= earlySync;
		end
	end

	// Early de doubles as the FIFO read enable
	assign o_fetch = earlySync.de;

endmodule

`default_nettype wire

// File: videoOutStage.sv
//------------------------------------------------
// Aligns FIFO data with syncs delayed by one cycle
// Blanking and underflowed pixels output zero
// o_underflow is sticky until iFRST
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module videoOutStage
(
	input  logic                  iFCLK,
	input  logic                  iFRST,
	input  videoPkg::syncBundle_t i_sync,
	input  logic                  i_fetch,
	input  videoPkg::pixel_t      i_rdData,
	input  logic                  i_empty,
	output videoPkg::syncBundle_t o_sync,
	output videoPkg::pixel_t      o_pixel,
	output logic                  o_underflow
);

	// Last fetch found the FIFO empty
	logic missed;

	always_ff @(posedge iFCLK)
	begin
		if (iFRST)
		begin
			o_sync      <= '0;
			o_pixel     <= '0;
			missed      <= 1'b0;
			o_underflow <= 1'b0;
		end
		else
		begin
			o_sync <= i_sync;
			missed <= i_fetch && i_empty;
			// Read data lines up with i_sync here, so both move on together
			// Zero outside active video and for missed pixels
			o_pixel <= (i_sync.de && !missed) ? i_rdData : '0;
			// Fetch on empty FIFO, flag stays set
			if (i_fetch && i_empty)
				o_underflow <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: videoPostProcess.sv
//------------------------------------------------
// Video post-processing top, single clock iFCLK
// Source must stop writing while o_full is high;
// the display side never stalls
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module videoPostProcess
(
	input  logic                  iFCLK,
	input  logic                  iFRST,
	input  videoPkg::pixel_t      i_pixel,
	input  logic                  i_pixelValid,
	output logic                  o_full,
	output videoPkg::syncBundle_t o_sync,
	output videoPkg::pixel_t      o_pixel,
	output logic                  o_underflow
);

	videoPkg::pixel_t      fifoRdData;
	logic                  fifoEmpty;
	logic                  timingRst;
	logic                  fetch;
	videoPkg::syncBundle_t genSync;

	//------------------------------------------------
	// Input side
	//------------------------------------------------
	pixelFifo pixelFifo_inst
	(
		.iFCLK    (iFCLK),
		.iFRST    (iFRST),
		.i_wrData (i_pixel),
		.i_wrEn   (i_pixelValid),
		.i_rdEn   (fetch),
		.o_rdData (fifoRdData),
		.o_full   (o_full),
		.o_empty  (fifoEmpty)
	);

	// Same strobe counts toward the prefill line
	startGate startGate_inst
	(
		.iFCLK       (iFCLK),
		.iFRST       (iFRST),
		.i_wrStrobe  (i_pixelValid),
		.o_timingRst (timingRst)
	);

	//------------------------------------------------
	// Timing and output side
	//------------------------------------------------
	videoTimingGen videoTimingGen_inst
	(
		.iFCLK       (iFCLK),
		.iFRST       (iFRST),
		.i_timingRst (timingRst),
		.o_sync      (genSync),
		.o_fetch     (fetch)
	);

	videoOutStage videoOutStage_inst
	(
		.iFCLK       (iFCLK),
		.iFRST       (iFRST),
		.i_sync      (genSync),
		.i_fetch     (fetch),
		.i_rdData    (fifoRdData),
		.i_empty     (fifoEmpty),
		.o_sync      (o_sync),
		.o_pixel     (o_pixel),
		.o_underflow (o_underflow)
	);

endmodule

`default_nettype wire

// File: tbVideoPostProcess.sv
//------------------------------------------------
// Self-checking testbench, source obeys o_full
// Model pops one pixel per output de cycle and
// runs up to two entries above the FIFO count
//------------------------------------------------
`timescale 1ns/1ns
`default_nettype none
`include "video_macros.svh"

module tbVideoPostProcess;

	localparam int CLK_PERIOD = 20;
	localparam int HTOT       = `VID_HACT + `VID_HFP + `VID_HSP + `VID_HBP;
	localparam int FRAME      = HTOT * (`VID_VACT + `VID_VFP + `VID_VSP + `VID_VBP);
	localparam int FULL_LEVEL = `FIFO_DEPTH - `FIFO_MARGIN;
	localparam int NUM_ROWS   = 5;

	// One burst of back to back writes, then a gap
	typedef struct packed
	{
		int burstLen;
		int gapCycles;
		int startVal;
	} row_t;

	logic                  iFCLK = 1'b0;
	logic                  iFRST;
	videoPkg::pixel_t      i_pixel;
	logic                  i_pixelValid;
	logic                  o_full;
	videoPkg::syncBundle_t o_sync;
	videoPkg::pixel_t      o_pixel;
	logic                  o_underflow;

	row_t                  rows [NUM_ROWS];
	videoPkg::pixel_t      scoreboard [$];
	int                    seed = 19224;
	int                    errCount = 0;
	int                    checks = 0;
	int                    errBase = 0;
	int                    testNo = 0;

	// Monitor state, sampled on the falling edge
	logic                  fullSeen = 1'b0;
	logic                  sawFullHigh = 1'b0;
	logic                  sawFullLow = 1'b0;
	logic                  modelUnder;
	logic                  prevUnder;
	videoPkg::syncBundle_t prevSync;
	int                    cycleNo = 0;
	int                    lastHsRise;
	int                    hsWidth;
	int                    deRun;
	int                    deRunsInFrame;
	logic                  vsSeen;
	int                    hsPeriods = 0;
	int                    framesDone = 0;

	videoPostProcess videoPostProcess_inst
	(
		.iFCLK        (iFCLK),
		.iFRST        (iFRST),
		.i_pixel      (i_pixel),
		.i_pixelValid (i_pixelValid),
		.o_full       (o_full),
		.o_sync       (o_sync),
		.o_pixel      (o_pixel),
		.o_underflow  (o_underflow)
	);

	always #(CLK_PERIOD / 2) iFCLK = ~iFCLK;

	//------------------------------------------------
	// Compare tasks
	//------------------------------------------------
	task automatic checkPixel(input string name, input videoPkg::pixel_t got,
		input videoPkg::pixel_t exp);
		checks++;
		if (got !== exp)
		begin
			errCount++;
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkSync(input string name, input videoPkg::syncBundle_t got,
		input videoPkg::syncBundle_t exp);
		checks++;
		if (got !== exp)
		begin
			errCount++;
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errCount++;
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// Run lengths and periods
	task automatic checkCount(input string name, input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			errCount++;
			$display("error %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic reportProblem(input string msg);
		errCount++;
		$display("%s", msg);
	endtask

	task automatic finishTest(input string name);
		testNo++;
		$display("test %0d %s: %0d errors", testNo, name, errCount - errBase);
		errBase = errCount;
	endtask

	//------------------------------------------------
	// Output monitor and reference model
	//------------------------------------------------
	task automatic clearModel();
		scoreboard.delete();
		prevSync = '0;
		prevUnder = 1'b0;
		modelUnder = 1'b0;
		lastHsRise = -1;
		hsWidth = 0;
		deRun = 0;
		deRunsInFrame = 0;
		vsSeen = 1'b0;
	endtask

	task automatic watchOutputs();
		videoPkg::syncBundle_t cur;
		videoPkg::pixel_t      nextPix;
		forever
		begin
			@(negedge iFCLK);
			cycleNo++;
			fullSeen = o_full;
			if (iFRST)
				clearModel();
			else
			begin
				cur = o_sync;
				// One fetch per de cycle, pixels leave in write order
				if (cur.de)
				begin
					if (scoreboard.size() > 0)
						nextPix = scoreboard.pop_front();
					else
					begin
						// Missed pixel shows as zero
						nextPix = '0;
						modelUnder = 1'b1;
					end
					checkPixel("o_pixel", o_pixel, nextPix);
					deRun++;
				end
				else
				begin
					checkPixel("o_pixel", o_pixel, '0);
					if (prevSync.de)
					begin
						checkCount("de run length", deRun, `VID_HACT);
						deRun = 0;
						deRunsInFrame++;
					end
				end
				// Flag rises one cycle ahead of its zero pixel
				checkBit("o_underflow", prevUnder, modelUnder);

				// Model runs 0 to 2 entries above the real count
				if (scoreboard.size() >= FULL_LEVEL + 2)
					checkBit("o_full", o_full, 1'b1);
				else if (scoreboard.size() < FULL_LEVEL)
					checkBit("o_full", o_full, 1'b0);
				if (o_full)
					sawFullHigh = 1'b1;
				else if (sawFullHigh)
					sawFullLow = 1'b1;

				// Line geometry
				if (cur.hSync && !prevSync.hSync)
				begin
					if (lastHsRise >= 0)
					begin
						checkCount("hSync period", cycleNo - lastHsRise, HTOT);
						hsPeriods++;
					end
					lastHsRise = cycleNo;
				end
				if (cur.hSync)
					hsWidth++;
				else if (prevSync.hSync)
				begin
					checkCount("hSync width", hsWidth, `VID_HSP);
					hsWidth = 0;
				end

				// Frame geometry
				if (cur.vSync && !prevSync.vSync)
				begin
					if (vsSeen)
					begin
						checkCount("de runs per frame", deRunsInFrame, `VID_VACT);
						framesDone++;
					end
					vsSeen = 1'b1;
					deRunsInFrame = 0;
				end

				prevSync = cur;
				prevUnder = o_underflow;
			end
		end
	endtask

	task automatic guardTimeout(input int limitCycles);
		repeat (limitCycles) @(posedge iFCLK);
		$display("timeout: run still going after %0d clock cycles", limitCycles);
		$display("Test failed");
		$finish;
	endtask

	//------------------------------------------------
	// Stimulus helpers
	//------------------------------------------------
	// Waits out o_full, drops valid at the end
	task automatic writeBurst(input int len, input int startVal);
		int               sent;
		videoPkg::pixel_t px;
		sent = 0;
		while (sent < len)
		begin
			@(posedge iFCLK);
			if (fullSeen)
				i_pixelValid <= 1'b0;
			else
			begin
				px = videoPkg::pixel_t'(16'(startVal + sent));
				i_pixel <= px;
				i_pixelValid <= 1'b1;
				scoreboard.push_back(px);
				sent++;
			end
		end
		@(posedge iFCLK);
		i_pixelValid <= 1'b0;
	endtask

	// Timing held, nothing flagged
	task automatic checkQuiet(input int cycles);
		repeat (cycles)
		begin
			@(negedge iFCLK);
			checkSync("o_sync", o_sync, '0);
			checkPixel("o_pixel", o_pixel, '0);
			checkBit("o_full", o_full, 1'b0);
			checkBit("o_underflow", o_underflow, 1'b0);
		end
	endtask

	task automatic applyReset();
		@(posedge iFCLK);
		iFRST <= 1'b1;
		repeat (3) @(posedge iFCLK);
		iFRST <= 1'b0;
	endtask

	//------------------------------------------------
	// Main sequence
	//------------------------------------------------
	initial
	begin
		int limit;
		int jitter;
		int r;
		iFRST = 1'b1;
		i_pixel = '0;
		i_pixelValid = 1'b0;

		// Burst, gap, first pixel value
		rows[0] = '{24, 2, 32'h1100};
		rows[1] = '{16, 3, 32'h2200};
		// Faster than the display drains
		rows[2] = '{48, 0, 32'h3300};
		rows[3] = '{16, 2, 32'h4400};
		// Long gap empties the FIFO
		rows[4] = '{4, 420, 32'h5500};

		// Writes may stall on o_full at about a third of the clock rate
		limit = 4 * (`PREFILL_COUNT - 1) + 3 * FRAME + 100;
		for (r = 0; r < NUM_ROWS; r++)
			limit += 4 * rows[r].burstLen + rows[r].gapCycles + 3;

		fork
			watchOutputs();
			guardTimeout(limit);
		join_none

		repeat (3) @(posedge iFCLK);
		iFRST <= 1'b0;

		// One pixel short of the prefill line
		checkQuiet(4);
		writeBurst(`PREFILL_COUNT - 1, 32'h0A00);
		checkQuiet(6);
		finishTest("held before prefill");

		for (r = 0; r < NUM_ROWS; r++)
		begin
			writeBurst(rows[r].burstLen, rows[r].startVal);
			jitter = $random(seed) & 3;
			repeat (rows[r].gapCycles + jitter) @(posedge iFCLK);
			finishTest($sformatf("row %0d", r));
		end

		@(negedge iFCLK);
		checkBit("o_underflow", o_underflow, 1'b1);
		if (!modelUnder)
			reportProblem("underflow row never ran the model queue empty");
		if (!sawFullHigh)
			reportProblem("o_full never rose during the fast row");
		if (!sawFullLow)
			reportProblem("o_full never fell again after rising");
		finishTest("full and underflow flags");

		if (hsPeriods == 0 || framesDone == 0)
			reportProblem("no complete line period or frame was measured");
		finishTest("frame geometry");

		// Sticky flag clears only here
		applyReset();
		checkQuiet(4);
		finishTest("reset recovery");

		$display("%0d tests, %0d checks, %0d errors", testNo, checks, errCount);
		if (errCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
videoPkg.sv
pixelFifo.sv
startGate.sv
videoTimingGen.sv
videoOutStage.sv
videoPostProcess.sv
tbVideoPostProcess.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the video post-processing testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f filelist.f --top-module tbVideoPostProcess -o simv

out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi
